/* logic/apb_pkg.sv */
package apb_pkg;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // One transfer as driven by the bus master.
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        logic      pready;
        logic      pslverr;
        apb_data_t prdata;
    } apb_rsp_t;

    // Byte offsets of the register map.
    typedef enum apb_addr_t {
        reg_op_a   = 8'h00,
        reg_op_b   = 8'h04,
        reg_ctrl   = 8'h08,
        reg_status = 8'h0C,
        reg_res_lo = 8'h10,
        reg_res_hi = 8'h14
    } reg_addr_e;

endpackage

/* logic/mul_pkg.sv */
package mul_pkg;

    localparam int default_data_width = 32;

    // Selects how the extra operand bit is filled.
    typedef enum logic {
        op_unsigned = 1'b0,
        op_signed   = 1'b1
    } mul_op_e;

    // CTRL register layout, bit 0 holds the opcode.
    typedef struct packed {
        mul_op_e op;
    } mul_ctrl_t;

    // STATUS register layout, busy in bit 0, done in bit 1.
    typedef struct packed {
        logic done;
        logic busy;
    } mul_status_t;

    typedef enum logic {
        st_idle = 1'b0,
        st_busy = 1'b1
    } mul_state_e;

endpackage

/* logic/booth_encoder.sv */
`timescale 1ns/1ns

module booth_encoder #(
    parameter int operand_width = 33
) (
    input  logic [operand_width-1:0]                            multiplicand,
    input  logic [operand_width-1:0]                            multiplier,
    output logic [(operand_width+3)/2-1:0][2*operand_width-1:0] rows
);

    localparam int digit_count = (operand_width - 1) / 2;
    localparam int row_width   = 2 * operand_width;

    // Sum of all the -2^k terms left by the sign-bit flips, taken modulo 2^row_width.
    function automatic logic [row_width-1:0] correction_const();
        logic [row_width-1:0] k;
        k = '0;
        k = k - (row_width'(1) << (operand_width - 1));
        for (int i = 0; i < digit_count; i++) begin
            k = k - (row_width'(1) << (operand_width + 1 + 2 * i));
        end
        return k;
    endfunction

    localparam logic [row_width-1:0] corr_const = correction_const();

    logic [digit_count-1:0] neg;
    logic [row_width-1:0]   corr_row;

    // Row for -b0 * A, the +1 of the negation sits in the correction row.
    assign rows[0] = row_width'(multiplier[0] ?
        {multiplicand[operand_width-1], ~multiplicand[operand_width-2:0]} :
        {1'b1, {(operand_width - 1){1'b0}}});

    for (genvar k = 0; k < digit_count; k++) begin : g_digit
        logic                 b0;
        logic                 b1;
        logic                 b2;
        logic                 one;
        logic                 two;
        logic [operand_width:0] mag;
        logic [operand_width:0] pp;

        assign b0 = multiplier[2*k];
        assign b1 = multiplier[2*k+1];
        assign b2 = multiplier[2*k+2];

        assign one    = b1 ^ b0;                               // Digit is +1 or -1.
        assign two    = (b2 & ~b1 & ~b0) | (~b2 & b1 & b0);    // Digit is +2 or -2.
        assign neg[k] = b2 & ~(b1 & b0);

        assign mag = one ? {multiplicand[operand_width-1], multiplicand} :
                     two ? {multiplicand, 1'b0} : '0;
        assign pp  = mag ^ {(operand_width + 1){neg[k]}};

        // Inverted sign bit replaces the sign extension.
        assign rows[k+1] = row_width'({~pp[operand_width], pp[operand_width-1:0]}) << (2 * k + 1);
    end

    // Leading-one pattern plus the negate bits of every row.
    always_comb begin
        corr_row    = corr_const;
        corr_row[0] = multiplier[0];
        for (int k = 0; k < digit_count; k++) begin
            corr_row[2*k+1] = neg[k];
        end
    end

    assign rows[digit_count+1] = corr_row;

endmodule

/* logic/csa_tree.sv */
`timescale 1ns/1ns

module csa_tree #(
    parameter int row_count = 18,
    parameter int row_width = 66
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [row_count-1:0][row_width-1:0] rows,
    output logic [row_width-1:0]                sum,
    output logic [row_width-1:0]                carry
);

    // Rows left after one level of 4:2 compressors.
    function automatic int next_count(int cnt);
        if (cnt <= 2) begin
            return cnt;
        end
        if (cnt % 4 == 3) begin
            return (cnt / 4) * 2 + 2;                          // Three leftovers take a padded cell.
        end
        return (cnt / 4) * 2 + cnt % 4;
    endfunction

    function automatic int count_at(int level);
        int cnt;
        cnt = row_count;
        for (int i = 0; i < level; i++) begin
            cnt = next_count(cnt);
        end
        return cnt;
    endfunction

    function automatic int tree_depth();
        int cnt;
        int d;
        cnt = row_count;
        d   = 0;
        while (cnt > 2) begin
            cnt = next_count(cnt);
            d++;
        end
        return d;
    endfunction

    localparam int depth = tree_depth();

    logic [depth:0][row_count-1:0][row_width-1:0] level;

    assign level[0] = rows;

    for (genvar l = 0; l < depth; l++) begin : g_level
        localparam int cnt      = count_at(l);
        localparam int groups   = cnt / 4 + ((cnt % 4 == 3) ? 1 : 0);
        localparam int spare    = (cnt % 4 == 3) ? 0 : cnt % 4;
        localparam int next_cnt = 2 * groups + spare;

        for (genvar g = 0; g < groups; g++) begin : g_cmp42
            logic [row_width-1:0] a;
            logic [row_width-1:0] b;
            logic [row_width-1:0] c;
            logic [row_width-1:0] d;
            logic [row_width-1:0] s1;
            logic [row_width-1:0] co;
            logic [row_width-1:0] ci;
            logic [row_width-1:0] cy;

            assign a = level[l][4*g];
            assign b = level[l][4*g+1];
            assign c = level[l][4*g+2];

            if (4 * g + 3 < cnt) begin : g_full
                assign d = level[l][4*g+3];
            end else begin : g_pad
                assign d = '0;
            end

            // First full adder, its carry feeds the next bit.
            assign s1 = a ^ b ^ c;
            assign co = (a & b) | (a & c) | (b & c);
            assign ci = {co[row_width-2:0], 1'b0};

            // Second full adder.
            assign cy = (s1 & d) | (s1 & ci) | (d & ci);

            assign level[l+1][2*g]   = s1 ^ d ^ ci;
            assign level[l+1][2*g+1] = {cy[row_width-2:0], 1'b0};
        end

        for (genvar j = 0; j < spare; j++) begin : g_pass
            assign level[l+1][2*groups+j] = level[l][4*groups+j];
        end

        for (genvar j = next_cnt; j < row_count; j++) begin : g_unused
            assign level[l+1][j] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sum   <= '0;
            carry <= '0;
        end else begin
            sum   <= level[depth][0];
            carry <= level[depth][1];
        end
    end

endmodule

/* logic/mul_core.sv */
`timescale 1ns/1ns

module mul_core #(
    parameter int data_width = 32
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  mul_pkg::mul_op_e        op,
    input  logic [data_width-1:0]   op_a,
    input  logic [data_width-1:0]   op_b,
    output logic [2*data_width-1:0] product,
    output logic                    product_valid
);

    import mul_pkg::*;

    localparam int operand_width = data_width + 1;
    localparam int row_width     = 2 * operand_width;
    localparam int row_count     = (operand_width + 3) / 2;

    typedef struct packed {
        logic [operand_width-1:0] a;
        logic [operand_width-1:0] b;
    } mul_req_t;

    mul_req_t                             req;
    logic [row_count-1:0][row_width-1:0] rows;
    logic [row_width-1:0]                tree_sum;
    logic [row_width-1:0]                tree_carry;
    logic [row_width-1:0]                total;
    logic                                tree_valid;

    // Extension bit is zero for unsigned, a sign copy for signed.
    assign req.a = {(op == op_signed) & op_a[data_width-1], op_a};
    assign req.b = {(op == op_signed) & op_b[data_width-1], op_b};

    booth_encoder #(
        .operand_width(operand_width)
    ) booth0 (
        .multiplicand(req.a),
        .multiplier  (req.b),
        .rows        (rows)
    );

    csa_tree #(
        .row_count(row_count),
        .row_width(row_width)
    ) tree0 (
        .clk  (clk),
        .reset(reset),
        .rows (rows),
        .sum  (tree_sum),
        .carry(tree_carry)
    );

    assign total = tree_sum + tree_carry;                      // Final carry-propagate add.

    always_ff @(posedge clk) begin
        if (reset) begin
            tree_valid    <= 1'b0;
            product_valid <= 1'b0;
        end else begin
            tree_valid    <= start;
            product_valid <= tree_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (tree_valid) begin
            product <= total[2*data_width-1:0];
        end
    end

endmodule

/* logic/mul_regs.sv */
`timescale 1ns/1ns

module mul_regs #(
    parameter int data_width = 32
) (
    input  logic                    clk,
    input  logic                    reset,
    input  apb_pkg::apb_req_t       apb_req,
    output apb_pkg::apb_rsp_t       apb_rsp,
    output logic                    start,
    output mul_pkg::mul_op_e        op,
    output logic [data_width-1:0]   op_a,
    output logic [data_width-1:0]   op_b,
    input  logic [2*data_width-1:0] product,
    input  logic                    product_valid
);

    import apb_pkg::*;
    import mul_pkg::*;

    reg_addr_e             addr;
    mul_state_e            state;
    mul_ctrl_t             ctrl;
    mul_status_t           status;
    logic                  done;
    logic                  busy;
    logic [data_width-1:0] res_lo;
    logic [data_width-1:0] res_hi;
    apb_data_t             rd_data;
    logic                  addr_hit;
    logic                  read_only;
    logic                  access;
    logic                  err;
    logic                  wr_ok;
    logic                  ctrl_go;

    assign addr   = reg_addr_e'(apb_req.paddr);
    assign access = apb_req.psel & apb_req.penable;
    assign busy   = (state == st_busy);
    assign status = '{done: done, busy: busy};
    assign op     = ctrl.op;

    always_comb begin
        rd_data  = '0;
        addr_hit = 1'b1;
        case (addr)
            reg_op_a:   rd_data[data_width-1:0] = op_a;
            reg_op_b:   rd_data[data_width-1:0] = op_b;
            reg_ctrl:   rd_data[$bits(mul_ctrl_t)-1:0] = ctrl;
            reg_status: rd_data[$bits(mul_status_t)-1:0] = status;
            reg_res_lo: rd_data[data_width-1:0] = res_lo;
            reg_res_hi: rd_data[data_width-1:0] = res_hi;
            default:    addr_hit = 1'b0;
        endcase
    end

    assign read_only = addr inside {reg_status, reg_res_lo, reg_res_hi};

    // Refused writes leave every register as it was.
    assign err     = ~addr_hit |
                     (apb_req.pwrite & (read_only | ((addr == reg_ctrl) & busy)));
    assign wr_ok   = access & apb_req.pwrite & ~err;
    assign ctrl_go = wr_ok & (addr == reg_ctrl);

    always_comb begin
        apb_rsp         = '0;
        apb_rsp.pready  = 1'b1;                                // No wait states.
        apb_rsp.pslverr = access & err;
        apb_rsp.prdata  = rd_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= st_idle;
            done   <= 1'b0;
            start  <= 1'b0;
            ctrl   <= '0;
            res_lo <= '0;
            res_hi <= '0;
        end else begin
            start <= ctrl_go;
            case (state)
                st_idle: begin
                    if (ctrl_go) begin
                        state <= st_busy;
                        done  <= 1'b0;
                    end
                end
                st_busy: begin
                    if (product_valid) begin
                        state <= st_idle;
                        done  <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
            if (ctrl_go) begin
                ctrl <= mul_ctrl_t'(apb_req.pwdata[$bits(mul_ctrl_t)-1:0]);
            end
            if (product_valid) begin
                {res_hi, res_lo} <= product;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok && addr == reg_op_a) begin
            op_a <= apb_req.pwdata[data_width-1:0];
        end
        if (wr_ok && addr == reg_op_b) begin
            op_b <= apb_req.pwdata[data_width-1:0];
        end
    end

endmodule

/* logic/apb_mul_top.sv */
`timescale 1ns/1ns

module apb_mul_top #(
    parameter int data_width = mul_pkg::default_data_width
) (
    input  logic              clk,
    input  logic              reset,
    input  apb_pkg::apb_req_t apb_req,
    output apb_pkg::apb_rsp_t apb_rsp
);

    import mul_pkg::*;

    logic                    start;
    mul_op_e                 op;
    logic [data_width-1:0]   op_a;
    logic [data_width-1:0]   op_b;
    logic [2*data_width-1:0] product;
    logic                    product_valid;

    mul_regs #(
        .data_width(data_width)
    ) regs0 (
        .clk          (clk),
        .reset        (reset),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .start        (start),
        .op           (op),
        .op_a         (op_a),
        .op_b         (op_b),
        .product      (product),
        .product_valid(product_valid)
    );

    mul_core #(
        .data_width(data_width)
    ) core0 (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .op           (op),
        .op_a         (op_a),
        .op_b         (op_b),
        .product      (product),
        .product_valid(product_valid)
    );

endmodule

/* tests/mul_vectors.svh */
`ifndef mul_vectors_svh
`define mul_vectors_svh

// Columns: test name, op_a, op_b, opcode.
typedef struct {
    string     name;
    apb_data_t a;
    apb_data_t b;
    mul_op_e   op;
} vector_t;

localparam int table_count = 16;

vector_t vectors [table_count] = '{
    '{"zero_u",        32'h0000_0000, 32'h1234_5678, op_unsigned},
    '{"zero_s",        32'hffff_ffff, 32'h0000_0000, op_signed},
    '{"one_u",         32'h0000_0001, 32'hffff_ffff, op_unsigned},
    '{"one_s",         32'h0000_0001, 32'hffff_ffff, op_signed},
    '{"ones_u",        32'hffff_ffff, 32'hffff_ffff, op_unsigned},
    '{"ones_s",        32'hffff_ffff, 32'hffff_ffff, op_signed},
    '{"min_neg_u",     32'h8000_0000, 32'h8000_0000, op_unsigned},
    '{"min_neg_s",     32'h8000_0000, 32'h8000_0000, op_signed},
    '{"min_by_ones_s", 32'h8000_0000, 32'hffff_ffff, op_signed},
    '{"max_by_min_s",  32'h7fff_ffff, 32'h8000_0000, op_signed},
    '{"alt_u",         32'haaaa_aaaa, 32'h5555_5555, op_unsigned},
    '{"alt_s",         32'haaaa_aaaa, 32'h5555_5555, op_signed},
    '{"alt_rev_s",     32'h5555_5555, 32'haaaa_aaaa, op_signed},
    '{"digits_u",      32'h1234_5678, 32'hcccc_3333, op_unsigned},
    '{"digits_s",      32'h9abc_def1, 32'hcccc_3333, op_signed},
    '{"digits_mix_s",  32'hfedc_ba98, 32'h0f0f_f0f0, op_signed}
};

`endif

/* tests/mul_tb.sv */
`timescale 1ns/1ns

module mul_tb;

    import apb_pkg::*;
    import mul_pkg::*;

    localparam int          clk_period   = 100;
    localparam int          drive_delay  = 10;
    localparam int          reset_cycles = 4;
    localparam int          random_count = 50;
    localparam logic [31:0] seed         = 32'h14b5d81b;

    `include "mul_vectors.svh"

    localparam int vector_count   = table_count + random_count;
    localparam int timeout_cycles = vector_count * 20 + 100;

    logic     clk;
    logic     reset;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    int       cycles;
    int       word_errors;
    int       status_errors;
    int       slverr_errors;
    int       ready_errors;

    apb_mul_top #(
        .data_width(32)
    ) dut0 (
        .clk    (clk),
        .reset  (reset),
        .apb_req(apb_req),
        .apb_rsp(apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Run timed out after %0d cycles without finishing the tests", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic check_word(input string name, input apb_data_t exp, input apb_data_t act);
        if (act !== exp) begin
            word_errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_status(input string name, input mul_status_t exp,
                                input mul_status_t act);
        if (act !== exp) begin
            status_errors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            slverr_errors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_ready(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            ready_errors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // Starts and ends a little after a rising edge.
    task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err, output logic ready);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #drive_delay;
        apb_req.penable = 1'b1;
        @(negedge clk);                                        // Response settled mid-cycle.
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        ready = apb_rsp.pready;
        @(posedge clk);
        #drive_delay;
        apb_req = '0;
    endtask

    task automatic apb_write(input string name, input apb_addr_t addr, input apb_data_t data,
                             input logic exp_err);
        apb_data_t rdata;
        logic      err;
        logic      ready;
        apb_access(1'b1, addr, data, rdata, err, ready);
        check_ready({name, " pready"}, 1'b1, ready);
        check_err({name, " pslverr"}, exp_err, err);
    endtask

    task automatic apb_read(input string name, input apb_addr_t addr, input logic exp_err,
                            output apb_data_t data);
        logic err;
        logic ready;
        apb_access(1'b0, addr, '0, data, err, ready);
        check_ready({name, " pready"}, 1'b1, ready);
        check_err({name, " pslverr"}, exp_err, err);
    endtask

    task automatic wait_done(input string name);
        mul_status_t status;
        apb_data_t   rdata;
        status = '0;
        while (!status.done) begin
            apb_read({name, " status"}, reg_status, 1'b0, rdata);
            status = mul_status_t'(rdata[$bits(mul_status_t)-1:0]);
        end
    endtask

    // Full 64-bit product of the operands read as signed or unsigned.
    function automatic logic [63:0] expected_product(input apb_data_t a, input apb_data_t b,
                                                     input mul_op_e op);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [63:0]        ua;
        logic [63:0]        ub;
        sa = $signed(a);
        sb = $signed(b);
        ua = {32'h0, a};
        ub = {32'h0, b};
        if (op == op_signed) begin
            return sa * sb;
        end
        return ua * ub;
    endfunction

    task automatic check_result(input string name, input logic [63:0] exp);
        apb_data_t lo;
        apb_data_t hi;
        apb_read({name, " res_lo"}, reg_res_lo, 1'b0, lo);
        apb_read({name, " res_hi"}, reg_res_hi, 1'b0, hi);
        check_word({name, " res_lo"}, exp[31:0], lo);
        check_word({name, " res_hi"}, exp[63:32], hi);
    endtask

    task automatic run_vector(input string name, input apb_data_t a, input apb_data_t b,
                              input mul_op_e op);
        apb_write({name, " op_a"}, reg_op_a, a, 1'b0);
        apb_write({name, " op_b"}, reg_op_b, b, 1'b0);
        apb_write({name, " ctrl"}, reg_ctrl, apb_data_t'(op), 1'b0);
        wait_done(name);
        check_result(name, expected_product(a, b, op));
    endtask

    initial begin
        apb_data_t rdata;
        apb_data_t a;
        apb_data_t b;
        cycles        = 0;
        word_errors   = 0;
        status_errors = 0;
        slverr_errors = 0;
        ready_errors  = 0;
        apb_req       = '0;
        reset         = 1'b1;
        void'($urandom(seed));
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        reset = 1'b0;

        apb_read("reset status", reg_status, 1'b0, rdata);
        check_status("reset status", '{done: 1'b0, busy: 1'b0}, mul_status_t'(rdata[1:0]));
        check_result("reset", 64'h0);

        for (int i = 0; i < table_count; i++) begin
            run_vector(vectors[i].name, vectors[i].a, vectors[i].b, vectors[i].op);
        end

        for (int i = 0; i < random_count; i++) begin
            a = $urandom();
            b = $urandom();
            run_vector($sformatf("random_%0d", i), a, b, (i % 2) ? op_signed : op_unsigned);
        end

        apb_write("busy start", reg_ctrl, apb_data_t'(op_unsigned), 1'b0);
        apb_read("busy status", reg_status, 1'b0, rdata);
        check_status("busy status", '{done: 1'b0, busy: 1'b1}, mul_status_t'(rdata[1:0]));
        wait_done("busy status");

        // Second CTRL write lands while the first multiply is in flight.
        apb_write("refused op_a", reg_op_a, 32'hffff_fffe, 1'b0);
        apb_write("refused op_b", reg_op_b, 32'h0000_0003, 1'b0);
        apb_write("refused start", reg_ctrl, apb_data_t'(op_signed), 1'b0);
        apb_write("refused ctrl", reg_ctrl, apb_data_t'(op_unsigned), 1'b1);
        wait_done("refused");
        check_result("refused", expected_product(32'hffff_fffe, 32'h0000_0003, op_signed));

        apb_write("write status", reg_status, 32'h3, 1'b1);
        apb_write("write res_lo", reg_res_lo, 32'h1234_5678, 1'b1);
        apb_write("write unmapped", 8'h18, 32'hdead_beef, 1'b1);
        apb_read("read unmapped", 8'h18, 1'b1, rdata);
        check_result("after refused writes",
                     expected_product(32'hffff_fffe, 32'h0000_0003, op_signed));

        apb_write("readback op_a", reg_op_a, 32'ha5a5_0f0f, 1'b0);
        apb_write("readback op_b", reg_op_b, 32'h1234_5678, 1'b0);
        apb_read("readback op_a", reg_op_a, 1'b0, rdata);
        check_word("readback op_a", 32'ha5a5_0f0f, rdata);
        apb_read("readback op_b", reg_op_b, 1'b0, rdata);
        check_word("readback op_b", 32'h1234_5678, rdata);

        $display("Errors: word %0d, status %0d, pslverr %0d, pready %0d",
                 word_errors, status_errors, slverr_errors, ready_errors);
        if (word_errors + status_errors + slverr_errors + ready_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+tests
logic/apb_pkg.sv
logic/mul_pkg.sv
logic/booth_encoder.sv
logic/csa_tree.sv
logic/mul_core.sv
logic/mul_regs.sv
logic/apb_mul_top.sv
tests/mul_tb.sv
